/* sources.f */
hw/pad_pkg.sv
hw/pad_bus_front.sv
hw/pad_encoder.sv
hw/multitap_scanner.sv
hw/pad_multitap.sv
dv/pad_multitap_tb.sv

/* dv/pad_multitap_tb.sv */
`timescale 1ns/1ps

module pad_multitap_tb
  import pad_pkg::*;
();

  localparam int NUM_PADS      = 4;
  // bus steps of the whole run, each settles for 5 cycles
  localparam int PLANNED_STEPS = 370;
  localparam int CYCLE_LIMIT   = 4 * PLANNED_STEPS * 6;

  logic          clk_sys_42_95;
  logic          rst;
  pad_buttons_t  pads [NUM_PADS];
  pad_settings_t settings;
  pad_bus_t      bus;
  nibble_t       joy_in;

  // reference model of the tap
  int          m_port;
  logic        m_phase;
  logic [3:0]  m_scans;
  // expected nibble, checked while check_en is high
  nibble_t     exp_nib;
  logic        check_en;
  int          checks_done;
  int          failures;
  int          cycle_cnt = 0;
  logic [31:0] lfsr;

  pad_multitap #(
    .NUM_PADS (NUM_PADS)
  ) uut (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst           (rst),
    .pads          (pads),
    .settings      (settings),
    .bus           (bus),
    .joy_in        (joy_in)
  );

  initial begin
    clk_sys_42_95 = 1'b0;
    forever #5 clk_sys_42_95 = ~clk_sys_42_95;
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h80200003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // slow follows scan bit 2, fast bit 1, others held
  function automatic logic turbo_gate(input turbo_rate_e rate, input logic [3:0] scans);
    if (rate == rate_slow) begin
      return scans[2];
    end
    if (rate == rate_fast) begin
      return scans[1];
    end
    return 1'b1;
  endfunction

  // console word for one player
  function automatic pad_word_t model_word(input pad_buttons_t b);
    logic one;
    logic two;
    // III and IV only feed turbo in two-button mode
    one = b.b1 | (~settings.button6_enable & b.b3
                  & turbo_gate(settings.button1_rate, m_scans));
    two = b.b2 | (~settings.button6_enable & b.b4
                  & turbo_gate(settings.button2_rate, m_scans));
    return {4'h0, ~b.b6, ~b.b5, ~b.b4, ~b.b3,
            ~b.left, ~b.down, ~b.right, ~b.up,
            ~b.start, ~b.select, ~two, ~one};
  endfunction

  function automatic nibble_t model_nibble();
    pad_word_t w;
    if (bus.clr) begin
      return 4'h0;
    end
    // empty ports look like idle pads
    w = (m_port < NUM_PADS) ? model_word(pads[m_port]) : 16'h0FFF;
    case ({m_phase, bus.sel})
      2'b00:   return w[3:0];
      2'b01:   return w[7:4];
      2'b10:   return w[11:8];
      default: return w[15:12];
    endcase
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clk_sys_42_95);
    #1;
  endtask

  // let the pipeline settle, then arm the checker for one edge
  task automatic settle_and_check();
    tick(4);
    exp_nib  = model_nibble();
    check_en = 1'b1;
    tick(1);
    check_en = 1'b0;
    checks_done++;
  endtask

  // drive clr/sel and step the model
  task automatic bus_step(input logic c, input logic s);
    logic clr_rose;
    logic sel_rose;
    clr_rose = c & ~bus.clr;
    sel_rose = s & ~bus.sel;
    bus.clr  = c;
    bus.sel  = s;
    if (clr_rose) begin
      m_scans = m_scans + 4'd1;
      m_phase = ~m_phase & settings.button6_enable;
    end
    if (c) begin
      m_port = 0;
    end else if (sel_rose && settings.turbo_tap_enable) begin
      m_port = (m_port + 1) % 8;
    end
    settle_and_check();
  endtask

  // CLR pulse, then walk all 8 port slots and back to port 0
  task automatic full_scan();
    bus_step(1'b1, 1'b1);
    bus_step(1'b0, 1'b1);
    for (int p = 0; p < 8; p++) begin
      bus_step(1'b0, 1'b0);
      bus_step(1'b0, 1'b1);
    end
  endtask

  // CLR pulse and the first player's nibbles only
  task automatic short_scan();
    bus_step(1'b1, 1'b1);
    bus_step(1'b0, 1'b1);
    bus_step(1'b0, 1'b0);
  endtask

  task automatic randomize_pads();
    logic [31:0] v;
    for (int i = 0; i < NUM_PADS; i++) begin
      take_bits(12, v);
      pads[i] = pad_buttons_t'(v[11:0]);
    end
    settle_and_check();
  endtask

  // III and IV held, I and II released, so bits 1:0 show the gates
  task automatic turbo_run(input turbo_rate_e r1, input turbo_rate_e r2);
    settings.button6_enable = 1'b0;
    settings.button1_rate   = r1;
    settings.button2_rate   = r2;
    for (int i = 0; i < NUM_PADS; i++) begin
      pads[i].b1 = 1'b0;
      pads[i].b2 = 1'b0;
      pads[i].b3 = 1'b1;
      pads[i].b4 = 1'b1;
    end
    settle_and_check();
    // 16 scans cover a full turn of the 4-bit scan count
    repeat (16) short_scan();
  endtask

  task automatic report_mismatch(input nibble_t expected, input nibble_t actual);
    failures++;
    $display("[FAIL] joy_in expected %h actual %h", expected, actual);
    $display("TEST FAIL");
    $fatal(1, "joy_in mismatch");
  endtask

  // joy_in against the model
  a_model_match: assert property (
    @(posedge clk_sys_42_95) disable iff (rst)
    check_en |-> (joy_in == exp_nib)
  ) else report_mismatch($sampled(exp_nib), $sampled(joy_in));

  // reset clears the latch
  a_reset_zero: assert property (
    @(posedge clk_sys_42_95)
    rst |=> (joy_in == 4'h0)
  ) else report_mismatch(4'h0, $sampled(joy_in));

  // two register stages after CLR is seen high, joy_in is 0
  a_clr_zero: assert property (
    @(posedge clk_sys_42_95) disable iff (rst)
    $past(bus.clr, 2) |-> (joy_in == 4'h0)
  ) else report_mismatch(4'h0, $sampled(joy_in));

  always @(posedge clk_sys_42_95) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst         = 1'b1;
    bus         = '0;
    settings    = '0;
    exp_nib     = '0;
    check_en    = 1'b0;
    checks_done = 0;
    failures    = 0;
    lfsr        = 32'h9111e5ce;
    m_port      = 0;
    m_phase     = 1'b0;
    m_scans     = '0;
    for (int i = 0; i < NUM_PADS; i++) begin
      pads[i] = '0;
    end
    repeat (16) @(posedge clk_sys_42_95);
    #1;
    rst = 1'b0;

    // idle pads right after reset
    settle_and_check();

    // tap walk over populated and empty ports
    settings.turbo_tap_enable = 1'b1;
    repeat (2) begin
      randomize_pads();
      full_scan();
    end

    // no tap, reading stays on player 1
    settings.turbo_tap_enable = 1'b0;
    randomize_pads();
    full_scan();

    // six-button pads, phase alternates per scan
    settings.turbo_tap_enable = 1'b1;
    settings.button6_enable   = 1'b1;
    randomize_pads();
    repeat (4) full_scan();
    // mode off, phase drops back and stays low
    settings.button6_enable = 1'b0;
    repeat (2) full_scan();

    // turbo rates on both buttons
    turbo_run(rate_slow, rate_fast);
    turbo_run(rate_fast, rate_slow);
    turbo_run(rate_off, rate_steady);
    turbo_run(rate_steady, rate_off);

    // long CLR hold
    bus_step(1'b1, 1'b0);
    tick(8);
    bus_step(1'b0, 1'b0);

    if (failures == 0 && checks_done > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hw/pad_multitap.sv */
`timescale 1ns/1ps

module pad_multitap
  import pad_pkg::*;
#(
  parameter int NUM_PADS = 4
) (
  input  logic          clk_sys_42_95,
  input  logic          rst,
  input  pad_buttons_t  pads [NUM_PADS],
  input  pad_settings_t settings,
  input  pad_bus_t      bus,
  output nibble_t       joy_in
);

  // registered bus levels and edges
  logic      clr_level;
  logic      sel_level;
  logic      clr_rise;
  logic      sel_rise;
  // turbo gates shared by every pad
  logic      turbo1_gate;
  logic      turbo2_gate;
  // one console word per attached pad
  pad_word_t word_bus [NUM_PADS];

  // bus sampling and turbo timing
  pad_bus_front u_front (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst           (rst),
    .bus           (bus),
    .button1_rate  (settings.button1_rate),
    .button2_rate  (settings.button2_rate),
    .clr_level     (clr_level),
    .sel_level     (sel_level),
    .clr_rise      (clr_rise),
    .sel_rise      (sel_rise),
    .turbo1_gate   (turbo1_gate),
    .turbo2_gate   (turbo2_gate)
  );

  // one encoder per pad
  for (genvar gi = 0; gi < NUM_PADS; gi++) begin : g_pad
    pad_encoder u_enc (
      .clk_sys_42_95  (clk_sys_42_95),
      .rst            (rst),
      .buttons        (pads[gi]),
      .button6_enable (settings.button6_enable),
      .turbo1_gate    (turbo1_gate),
      .turbo2_gate    (turbo2_gate),
      .word           (word_bus[gi])
    );
  end

  // tap port walk and nibble latch
  multitap_scanner #(
    .NUM_PADS (NUM_PADS)
  ) u_scan (
    .clk_sys_42_95    (clk_sys_42_95),
    .rst              (rst),
    .clr_level        (clr_level),
    .sel_level        (sel_level),
    .clr_rise         (clr_rise),
    .sel_rise         (sel_rise),
    .turbo_tap_enable (settings.turbo_tap_enable),
    .button6_enable   (settings.button6_enable),
    .word_bus         (word_bus),
    .joy_in           (joy_in)
  );

endmodule

/* hw/multitap_scanner.sv */
`timescale 1ns/1ps

module multitap_scanner
  import pad_pkg::*;
#(
  parameter int NUM_PADS = 4
) (
  input  logic      clk_sys_42_95,
  input  logic      rst,
  input  logic      clr_level,
  input  logic      sel_level,
  input  logic      clr_rise,
  input  logic      sel_rise,
  input  logic      turbo_tap_enable,
  input  logic      button6_enable,
  input  pad_word_t word_bus [NUM_PADS],
  output nibble_t   joy_in
);

  // current multitap port
  port_idx_t port;
  // high-button phase of six-button pads
  logic      high_phase;
  // word of the selected port
  pad_word_t cur_word;
  // which nibble of cur_word goes out
  logic [1:0] nib_sel;
  nibble_t   nib_next;

  // port mux, unpopulated ports read idle
  always_comb begin
    cur_word = PAD_WORD_IDLE;
    for (int i = 0; i < NUM_PADS; i++) begin
      if (port == port_idx_t'(i)) begin
        cur_word = word_bus[i];
      end
    end
  end

  // 0 run/sel/II/I, 1 dpad, 2 III..VI, 3 always 0
  assign nib_sel  = {high_phase, sel_level};
  assign nib_next = cur_word[{nib_sel, 2'b00} +: 4];

  // port stepping and phase
  always_ff @(posedge clk_sys_42_95) begin
    if (rst) begin
      port       <= '0;
      high_phase <= 1'b0;
    end else if (clr_level) begin
      // CLR rewinds the tap to the first pad
      port <= '0;
      if (clr_rise) begin
        // alternate scans only with six-button pads
        high_phase <= ~high_phase & button6_enable;
      end
    end else if (sel_rise && turbo_tap_enable) begin
      // wraps past 7
      port <= port + port_idx_t'(1);
    end
  end

  // nibble latch back to the console
  always_ff @(posedge clk_sys_42_95) begin
    if (rst) begin
      joy_in <= '0;
    end else if (clr_level) begin
      // held at zero for the whole CLR pulse
      joy_in <= '0;
    end else begin
      joy_in <= nib_next;
    end
  end

  // console must see all lines low right after CLR
  a_clr_zero: assert property (
    @(posedge clk_sys_42_95) disable iff (rst)
    clr_level |=> (joy_in == '0)
  );

endmodule

/* hw/pad_encoder.sv */
`timescale 1ns/1ps

module pad_encoder
  import pad_pkg::*;
(
  input  logic         clk_sys_42_95,
  input  logic         rst,
  input  pad_buttons_t buttons,
  input  logic         button6_enable,
  input  logic         turbo1_gate,
  input  logic         turbo2_gate,
  output pad_word_t    word
);

  // turbo contributions from III and IV
  logic      turbo_i;
  logic      turbo_ii;
  // buttons I and II after merging turbo
  logic      btn_i;
  logic      btn_ii;
  // next console word, still active high
  pad_word_t word_hi;

  always_comb begin
    // III and IV act as turbo I and II only in two-button mode
    turbo_i  = ~button6_enable & buttons.b3 & turbo1_gate;
    turbo_ii = ~button6_enable & buttons.b4 & turbo2_gate;
    btn_i    = buttons.b1 | turbo_i;
    btn_ii   = buttons.b2 | turbo_ii;
  end

  always_comb begin
    // unused top nibble reads as pressed, so the inverse gives 0
    word_hi[15:12] = 4'hF;
    // high buttons for the six-button phase
    word_hi[11]    = buttons.b6;
    word_hi[10]    = buttons.b5;
    word_hi[9]     = buttons.b4;
    word_hi[8]     = buttons.b3;
    // dpad nibble, console order
    word_hi[7]     = buttons.left;
    word_hi[6]     = buttons.down;
    word_hi[5]     = buttons.right;
    word_hi[4]     = buttons.up;
    // run, select, II, I
    word_hi[3]     = buttons.start;
    word_hi[2]     = buttons.select;
    word_hi[1]     = btn_ii;
    word_hi[0]     = btn_i;
  end

  // console wants active low
  always_ff @(posedge clk_sys_42_95) begin
    if (rst) begin
      // nothing pressed
      word <= PAD_WORD_IDLE;
    end else begin
      word <= ~word_hi;
    end
  end

endmodule

/* hw/pad_bus_front.sv */
`timescale 1ns/1ps

module pad_bus_front
  import pad_pkg::*;
(
  input  logic        clk_sys_42_95,
  input  logic        rst,
  input  pad_bus_t    bus,
  input  turbo_rate_e button1_rate,
  input  turbo_rate_e button2_rate,
  output logic        clr_level,
  output logic        sel_level,
  output logic        clr_rise,
  output logic        sel_rise,
  output logic        turbo1_gate,
  output logic        turbo2_gate
);

  // registered bus and the value one cycle older
  pad_bus_t   bus_q;
  pad_bus_t   bus_prev;
  // counts CLR rises, drives the turbo gates
  logic [3:0] scan_cnt;

  // gate for one turbo button
  // slow toggles every 4 scans, fast every 2
  function automatic logic rate_gate(input turbo_rate_e rate, input logic [3:0] cnt);
    case (rate)
      rate_slow: rate_gate = cnt[2];
      rate_fast: rate_gate = cnt[1];
      // off and steady leave the button held
      default:   rate_gate = 1'b1;
    endcase
  endfunction

  always_ff @(posedge clk_sys_42_95) begin
    if (rst) begin
      bus_q    <= '0;
      bus_prev <= '0;
    end else begin
      bus_q    <= bus;
      bus_prev <= bus_q;
    end
  end

  // levels straight from the first register stage
  assign clr_level = bus_q.clr;
  assign sel_level = bus_q.sel;

  // one cycle pulses on low to high of the registered levels
  assign clr_rise = bus_q.clr & ~bus_prev.clr;
  assign sel_rise = bus_q.sel & ~bus_prev.sel;

  // scan counter, one step per CLR rise
  always_ff @(posedge clk_sys_42_95) begin
    if (rst) begin
      scan_cnt <= '0;
    end else if (clr_rise) begin
      scan_cnt <= scan_cnt + 4'd1;
    end
  end

  assign turbo1_gate = rate_gate(button1_rate, scan_cnt);
  assign turbo2_gate = rate_gate(button2_rate, scan_cnt);

  // turbo phase only ever moves on a console scan
  a_cnt_on_scan: assert property (
    @(posedge clk_sys_42_95) disable iff (rst)
    (scan_cnt != $past(scan_cnt)) |-> ($past(clr_rise) || $past(rst))
  );

endmodule

/* hw/pad_pkg.sv */
package pad_pkg;

  // nibble driven back onto the console data lines
  typedef logic [3:0] nibble_t;

  // console pad word, active low
  // 15:12 unused, 11:8 high buttons, 7:4 dpad, 3:0 run/select/II/I
  typedef logic [15:0] pad_word_t;

  // multitap port counter, wraps at 8
  typedef logic [2:0] port_idx_t;

  // word seen on an empty port or a pad with nothing pressed
  localparam pad_word_t PAD_WORD_IDLE = 16'h0FFF;

  // raw buttons of one player, active high
  typedef struct packed {
    logic b6;
    logic b5;
    logic b4;
    logic b3;
    logic start;
    logic select;
    logic b2;
    logic b1;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_buttons_t;

  // console side of the pad bus
  typedef struct packed {
    logic clr;
    logic sel;
  } pad_bus_t;

  // turbo speed for buttons I and II
  typedef enum logic [1:0] {
    rate_off    = 2'd0,
    rate_slow   = 2'd1,
    rate_fast   = 2'd2,
    rate_steady = 2'd3
  } turbo_rate_e;

  // static user settings
  typedef struct packed {
    logic        turbo_tap_enable;
    logic        button6_enable;
    turbo_rate_e button1_rate;
    turbo_rate_e button2_rate;
  } pad_settings_t;

endpackage
